// File: project.f
src/la_isa_pkg.sv
src/id_pipe_pkg.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_bypass.sv
src/branch_unit.sv
src/id_stage.sv
testbench/id_stage_props.sv
testbench/id_checker.sv
testbench/tb_id_stage.sv

// File: run_sim.sh
#!/bin/sh
# build and run the id_stage testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_id_stage \
  -f project.f -o sim_id_stage
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_id_stage +verilator+error+limit+100000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  exit 1
fi
exit 0

// File: testbench/tb_id_stage.sv
`default_nettype none

module tb_id_stage;

  timeunit 1ns;
  timeprecision 1ps;

  import la_isa_pkg::*;
  import id_pipe_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int FILL_CYCLES  = 31;  // r1..r31 get a value before any read
  localparam int TEST_CYCLES  = 600;
  localparam int WATCHDOG_NS  = (FILL_CYCLES + TEST_CYCLES + 50) * CLK_PERIOD;

  localparam logic [4:0] REG3_F5 [11] = '{F5_ADD, F5_SUB, F5_SLT, F5_SLTU, F5_AND, F5_OR,
                                          F5_NOR, F5_XOR, F5_SLL, F5_SRL, F5_SRA};
  localparam logic [4:0] SHIFT_F5 [3] = '{F5_SLLI, F5_SRLI, F5_SRAI};
  localparam logic [3:0] IMM_F4 [8]   = '{F4_SLTI, F4_SLTUI, F4_ADDI, F4_ANDI, F4_ORI, F4_XORI,
                                          F4_LD_W, F4_ST_W};
  localparam logic [5:0] MAJOR_OP [11] = '{OP_LU12I, OP_PCADDU12I, OP_JIRL, OP_B, OP_BL,
                                           OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};

  logic   clk;
  logic   resetn;
  logic   if_id_valid;
  if_id_t if_id;
  logic   id_allowin;
  logic   ex_allowin;
  logic   id_ex_valid;
  id_ex_t id_ex;
  br_t    br;
  fwd_t   ex_fwd;
  fwd_t   mem_fwd;
  fwd_t   wb_fwd;
  int     tests_passed;
  int     tests_failed;
  int     errors;
  int     assert_fails;
  integer seed = 32'hfa95_a0fd;

  id_stage i_id_stage (.*);

  id_checker i_id_checker (.*);

  bind id_stage id_stage_props i_id_stage_props (
    .clk         (clk),
    .resetn      (resetn),
    .id_valid    (id_valid),
    .stall       (stall),
    .ex_allowin  (ex_allowin),
    .id_allowin  (id_allowin),
    .id_ex_valid (id_ex_valid),
    .id_ex       (id_ex),
    .br          (br)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // random kept instruction with rd, rj and rk in r0..r7
  function automatic inst_t random_inst();
    inst_t     r;
    reg_addr_t rd;
    reg_addr_t rj;
    reg_addr_t rk;
    int        sel;
    r   = 32'($random(seed));
    rd  = 5'($random(seed)) & 5'h7;
    rj  = 5'($random(seed)) & 5'h7;
    rk  = 5'($random(seed)) & 5'h7;
    sel = {$random(seed)} % 33;
    if (sel < 11) begin
      r = {OP_ALU, F4_REG3, F2_REG3, REG3_F5[sel], rk, rj, rd};
    end else if (sel < 14) begin
      r = {OP_ALU, F4_SHIFTI, F2_SHIFTI, SHIFT_F5[sel - 11], rk, rj, rd};
    end else if (sel < 22) begin
      r = {(sel < 20) ? OP_ALU : OP_MEM, IMM_F4[sel - 14], r[21:10], rj, rd};
    end else begin
      r = {MAJOR_OP[sel - 22], r[25:10], rj, rd};
      if (sel < 24) r[25] = 1'b0;  // 7-bit opcode
    end
    return r;
  endfunction

  // small values now and then so that branch compares hit equality
  function automatic fwd_t random_fwd(input logic may_load, input logic enable);
    fwd_t f;
    f.we       = enable && (($random(seed) & 1) != 0);
    f.waddr    = 5'($random(seed)) & 5'h7;
    f.wdata    = (($random(seed) & 1) != 0) ? 32'($random(seed)) : 32'($random(seed)) & 32'h3;
    f.from_mem = may_load && f.we && (($random(seed) & 3) == 0);
    return f;
  endfunction

  task automatic drive_cycle(input logic hazards);
    if_id_valid <= ($random(seed) & 3) != 0;
    if_id.inst  <= random_inst();
    if_id.pc    <= 32'($random(seed)) & 32'hffff_fffc;
    ex_allowin  <= ($random(seed) & 3) != 0;
    ex_fwd      <= random_fwd(1'b1, hazards);
    mem_fwd     <= random_fwd(1'b0, hazards);
    wb_fwd      <= random_fwd(1'b0, 1'b1);
  endtask

  initial begin
    resetn      = 1'b0;
    if_id_valid = 1'b0;
    if_id       = '0;
    ex_allowin  = 1'b1;
    ex_fwd      = '0;
    mem_fwd     = '0;
    wb_fwd      = '0;
    for (int i = 1; i <= FILL_CYCLES; i++) begin
      @(posedge clk);
      wb_fwd <= '{from_mem: 1'b0, we: 1'b1, waddr: 5'(i), wdata: 32'($random(seed))};
      if (i == RESET_CYCLES) begin
        resetn <= 1'b1;
      end
    end
    for (int c = 0; c < TEST_CYCLES; c++) begin
      @(posedge clk);
      drive_cycle(c >= TEST_CYCLES / 3);  // first third without EX/MEM results
    end
    @(posedge clk);
    if_id_valid <= 1'b0;
    ex_allowin  <= 1'b1;
    ex_fwd      <= '0;
    mem_fwd     <= '0;
    wb_fwd      <= '0;
    repeat (4) @(posedge clk);
    assert_fails = i_id_stage.i_id_stage_props.assert_fails;
    $display("summary: %0d passed, %0d failed, %0d check errors, %0d assertion failures",
             tests_passed, tests_failed, errors, assert_fails);
    if (tests_failed == 0 && errors == 0 && assert_fails == 0 && tests_passed > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/id_checker.sv
`default_nettype none

module id_checker (
  input  logic                clk,
  input  logic                resetn,
  input  logic                if_id_valid,
  input  id_pipe_pkg::if_id_t if_id,
  input  logic                ex_allowin,
  input  logic                id_allowin,
  input  logic                id_ex_valid,
  input  id_pipe_pkg::id_ex_t id_ex,
  input  id_pipe_pkg::br_t    br,
  input  id_pipe_pkg::fwd_t   ex_fwd,
  input  id_pipe_pkg::fwd_t   mem_fwd,
  input  id_pipe_pkg::fwd_t   wb_fwd,
  output int                  tests_passed,
  output int                  tests_failed,
  output int                  errors
);

  timeunit 1ns;
  timeprecision 1ps;

  import la_isa_pkg::*;
  import id_pipe_pkg::*;

  word_t     m_rf [32] = '{default: '0};  // model register file
  logic      m_valid = 1'b0;
  if_id_t    m_slot;
  logic      slot_bad;
  alu_op_t   m_op;
  logic      m_pc1, m_imm2, m_nr1, m_nr2, m_we, m_ld, m_st, m_br;
  reg_addr_t m_wa;
  reg_addr_t m_ra2;
  word_t     m_imm;
  word_t     m_offs;

  initial begin
    tests_passed = 0;
    tests_failed = 0;
    errors       = 0;
  end

  // expected control fields, straight from the encoding tables
  task automatic decode_model(input inst_t in);
    m_op  = '0;
    {m_pc1, m_imm2, m_nr1, m_nr2, m_we, m_ld, m_st, m_br} = '0;
    m_wa   = in[4:0];
    m_ra2  = in[14:10];
    m_imm  = {{20{in[21]}}, in[21:10]};  // si12 unless noted
    m_offs = {{14{in[25]}}, in[25:10], 2'b00};
    case (in[31:26])
      OP_ALU: begin
        if (in[25:20] == {F4_REG3, F2_REG3}) begin
          case (in[19:15])
            F5_ADD:  m_op[ALU_ADD]  = 1'b1;
            F5_SUB:  m_op[ALU_SUB]  = 1'b1;
            F5_SLT:  m_op[ALU_SLT]  = 1'b1;
            F5_SLTU: m_op[ALU_SLTU] = 1'b1;
            F5_AND:  m_op[ALU_AND]  = 1'b1;
            F5_OR:   m_op[ALU_OR]   = 1'b1;
            F5_NOR:  m_op[ALU_NOR]  = 1'b1;
            F5_XOR:  m_op[ALU_XOR]  = 1'b1;
            F5_SLL:  m_op[ALU_SLL]  = 1'b1;
            F5_SRL:  m_op[ALU_SRL]  = 1'b1;
            F5_SRA:  m_op[ALU_SRA]  = 1'b1;
            default: ;
          endcase
          {m_nr1, m_nr2, m_we} = {3{m_op != '0}};
        end else if (in[25:20] == {F4_SHIFTI, F2_SHIFTI}) begin
          case (in[19:15])
            F5_SLLI: m_op[ALU_SLL] = 1'b1;
            F5_SRLI: m_op[ALU_SRL] = 1'b1;
            F5_SRAI: m_op[ALU_SRA] = 1'b1;
            default: ;
          endcase
          {m_nr1, m_imm2, m_we} = {3{m_op != '0}};
        end else begin
          case (in[25:22])
            F4_SLTI:  m_op[ALU_SLT]  = 1'b1;
            F4_SLTUI: m_op[ALU_SLTU] = 1'b1;
            F4_ADDI:  m_op[ALU_ADD]  = 1'b1;
            F4_ANDI:  m_op[ALU_AND]  = 1'b1;
            F4_ORI:   m_op[ALU_OR]   = 1'b1;
            F4_XORI:  m_op[ALU_XOR]  = 1'b1;
            default: ;
          endcase
          if (in[25:22] inside {F4_ANDI, F4_ORI, F4_XORI}) m_imm = {20'b0, in[21:10]};
          {m_nr1, m_imm2, m_we} = {3{m_op != '0}};
        end
      end
      OP_MEM: begin
        m_ld = (in[25:22] == F4_LD_W);
        m_st = (in[25:22] == F4_ST_W);
        m_op[ALU_ADD] = m_ld | m_st;
        {m_nr1, m_imm2} = {2{m_ld | m_st}};
        m_we  = m_ld;
        m_nr2 = m_st;
        if (m_st) m_ra2 = in[4:0];  // store data comes from rd
      end
      OP_LU12I, OP_PCADDU12I: begin
        m_pc1 = (in[31:26] == OP_PCADDU12I);
        m_op[ALU_LUI] = !m_pc1;
        m_op[ALU_ADD] = m_pc1;
        {m_imm2, m_we} = 2'b11;
        m_imm = {in[24:5], 12'b0};
      end
      OP_JIRL, OP_BL: begin
        m_op[ALU_ADD] = 1'b1;
        {m_pc1, m_imm2, m_we, m_br} = 4'b1111;
        m_imm = 32'd4;  // link address
        m_nr1 = (in[31:26] == OP_JIRL);
        if (!m_nr1) m_wa = REG_LINK;
        if (!m_nr1) m_offs = {{4{in[9]}}, in[9:0], in[25:10], 2'b00};
      end
      OP_B: begin
        m_br   = 1'b1;
        m_offs = {{4{in[9]}}, in[9:0], in[25:10], 2'b00};
      end
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
        {m_br, m_nr1, m_nr2} = 3'b111;
        m_ra2 = in[4:0];
      end
      default: ;
    endcase
  endtask

  // youngest stage first, r0 reads zero
  function automatic word_t operand(input reg_addr_t a);
    if (a == '0) return '0;
    if (ex_fwd.we && ex_fwd.waddr == a) return ex_fwd.wdata;
    if (mem_fwd.we && mem_fwd.waddr == a) return mem_fwd.wdata;
    if (wb_fwd.we && wb_fwd.waddr == a) return wb_fwd.wdata;
    return m_rf[a];
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t got);
    if (exp !== got) begin
      $display("[FAIL] %s expected %h got %h at %0t", name, exp, got, $time);
      errors++;
      slot_bad = 1'b1;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (exp !== got) begin
      $display("[FAIL] %s expected %h got %h at %0t", name, exp, got, $time);
      errors++;
      slot_bad = 1'b1;
    end
  endtask

  task automatic finish_test(input string how);
    if (slot_bad) tests_failed++;
    else tests_passed++;
    $display("test %0d pc %h inst %h %s: %s", tests_passed + tests_failed, m_slot.pc,
             m_slot.inst, how, slot_bad ? "mismatch" : "ok");
  endtask

  // outputs settle between edges, so compare on the falling edge
  always @(negedge clk) begin : compare
    word_t rj;
    word_t rkd;
    logic  stl;
    logic  cond;
    logic  taken;
    logic  allow;
    if (!resetn) begin
      check_bit("id_allowin", 1'b1, id_allowin);
      check_bit("id_ex_valid", 1'b0, id_ex_valid);
      check_bit("br.taken", 1'b0, br.taken);
      check_bit("br.stall", 1'b0, br.stall);
      m_valid = 1'b0;
    end else begin
      decode_model(m_slot.inst);
      rj  = operand(m_slot.inst[9:5]);
      rkd = operand(m_ra2);
      stl = m_valid && ex_fwd.we && ex_fwd.from_mem && (ex_fwd.waddr != '0)
         && ((m_nr1 && ex_fwd.waddr == m_slot.inst[9:5]) || (m_nr2 && ex_fwd.waddr == m_ra2));
      cond = 1'b1;  // b, bl, jirl
      case (m_slot.inst[31:26])
        OP_BEQ:  cond = (rj == rkd);
        OP_BNE:  cond = (rj != rkd);
        OP_BLT:  cond = ($signed(rj) < $signed(rkd));
        OP_BGE:  cond = ($signed(rj) >= $signed(rkd));
        OP_BLTU: cond = (rj < rkd);
        OP_BGEU: cond = (rj >= rkd);
        default: ;
      endcase
      taken = m_valid && !stl && m_br && cond;
      allow = !m_valid || (!stl && ex_allowin);
      if (m_valid) begin
        check_word("id_ex.alu_op", 32'(m_op), 32'(id_ex.alu_op));
        check_word("id_ex.alu_src1", m_pc1 ? m_slot.pc : rj, id_ex.alu_src1);
        check_word("id_ex.alu_src2", m_imm2 ? m_imm : rkd, id_ex.alu_src2);
        check_word("id_ex.rkd_value", rkd, id_ex.rkd_value);
        check_word("id_ex.pc", m_slot.pc, id_ex.pc);
        check_word("id_ex.rf_waddr", 32'(m_wa), 32'(id_ex.rf_waddr));
        check_bit("id_ex.rf_we", m_we, id_ex.rf_we);
        check_bit("id_ex.res_from_mem", m_ld, id_ex.res_from_mem);
        check_bit("id_ex.mem_we", m_st, id_ex.mem_we);
        if (m_br) begin
          check_word("br.target", ((m_slot.inst[31:26] == OP_JIRL) ? rj : m_slot.pc) + m_offs,
                     br.target);
        end
      end
      check_bit("id_allowin", allow, id_allowin);
      check_bit("id_ex_valid", m_valid && !stl, id_ex_valid);
      check_bit("br.taken", taken, br.taken);
      check_bit("br.stall", m_valid && stl && m_br, br.stall);
      if (m_valid && (taken || (!stl && ex_allowin))) begin
        finish_test(taken ? "branch taken" : "issued");
      end
      if (taken) begin
        m_valid = 1'b0;  // flush beats capture
      end else if (allow) begin
        m_valid  = if_id_valid;
        m_slot   = if_id;
        slot_bad = 1'b0;
      end
    end
    if (wb_fwd.we && wb_fwd.waddr != '0) m_rf[wb_fwd.waddr] = wb_fwd.wdata;
  end

endmodule

`default_nettype wire

// File: testbench/id_stage_props.sv
`default_nettype none

module id_stage_props (
  input logic                clk,
  input logic                resetn,
  input logic                id_valid,
  input logic                stall,
  input logic                ex_allowin,
  input logic                id_allowin,
  input logic                id_ex_valid,
  input id_pipe_pkg::id_ex_t id_ex,
  input id_pipe_pkg::br_t    br
);

  timeunit 1ns;
  timeprecision 1ps;

  int assert_fails = 0;  // read by the testbench top

  // the cycle after any reset cycle is idle
  reset_idle: assert property (@(posedge clk)
    !resetn |=> !id_ex_valid && !br.taken && !br.stall && id_allowin)
    else begin
      $error("outputs not idle after reset");
      assert_fails++;
    end

  // a stalled instruction stays in the slot
  load_use_hold: assert property (@(posedge clk) disable iff (!resetn)
    id_valid && stall |=> id_valid && $stable(id_ex.pc) && $stable(id_ex.alu_op))
    else begin
      $error("stalled instruction was not held");
      assert_fails++;
    end

  // flush is the only way out while EX is full
  backpressure_hold: assert property (@(posedge clk) disable iff (!resetn)
    id_valid && !ex_allowin && !br.taken |=> id_valid && $stable(id_ex.pc)
      && $stable(id_ex.alu_op) && $stable(id_ex.rf_waddr))
    else begin
      $error("id_ex changed under back-pressure");
      assert_fails++;
    end

endmodule

`default_nettype wire

// File: src/id_stage.sv
`default_nettype none

module id_stage (
  input  logic                clk,
  input  logic                resetn,
  input  logic                if_id_valid,
  input  id_pipe_pkg::if_id_t if_id,
  output logic                id_allowin,
  input  logic                ex_allowin,
  output logic                id_ex_valid,
  output id_pipe_pkg::id_ex_t id_ex,
  output id_pipe_pkg::br_t    br,
  input  id_pipe_pkg::fwd_t   ex_fwd,
  input  id_pipe_pkg::fwd_t   mem_fwd,
  input  id_pipe_pkg::fwd_t   wb_fwd
);

  import la_isa_pkg::*;
  import id_pipe_pkg::*;

  logic   id_valid;
  if_id_t id_slot;  // fetched pc and inst
  dec_t   dec;
  word_t  rf_rdata1;
  word_t  rf_rdata2;
  word_t  rj_value;
  word_t  rkd_value;
  logic   stall;

  assign id_allowin  = !id_valid || (!stall && ex_allowin);
  assign id_ex_valid = id_valid && !stall;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      id_valid <= 1'b0;
    end else if (br.taken) begin
      id_valid <= 1'b0;  // flush wins over new capture
    end else if (id_allowin) begin
      id_valid <= if_id_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (if_id_valid && id_allowin) begin
      id_slot <= if_id;
    end
  end

  inst_decoder i_inst_decoder (
    .inst (id_slot.inst),
    .dec  (dec)
  );

  regfile i_regfile (
    .clk    (clk),
    .raddr1 (dec.raddr1),
    .rdata1 (rf_rdata1),
    .raddr2 (dec.raddr2),
    .rdata2 (rf_rdata2),
    .we     (wb_fwd.we),
    .waddr  (wb_fwd.waddr),
    .wdata  (wb_fwd.wdata)
  );

  operand_bypass i_operand_bypass (
    .dec       (dec),
    .rdata1    (rf_rdata1),
    .rdata2    (rf_rdata2),
    .ex_fwd    (ex_fwd),
    .mem_fwd   (mem_fwd),
    .wb_fwd    (wb_fwd),
    .rj_value  (rj_value),
    .rkd_value (rkd_value),
    .stall     (stall)
  );

  branch_unit i_branch_unit (
    .dec       (dec),
    .pc        (id_slot.pc),
    .rj_value  (rj_value),
    .rkd_value (rkd_value),
    .valid     (id_valid),
    .stall     (stall),
    .br        (br)
  );

  assign id_ex.alu_op       = dec.alu_op;
  assign id_ex.res_from_mem = dec.res_from_mem;
  assign id_ex.mem_we       = dec.mem_we;
  assign id_ex.alu_src1     = dec.src1_is_pc ? id_slot.pc : rj_value;
  assign id_ex.alu_src2     = dec.src2_is_imm ? dec.imm : rkd_value;
  assign id_ex.rf_we        = dec.rf_we;
  assign id_ex.rf_waddr     = dec.rf_waddr;
  assign id_ex.rkd_value    = rkd_value;  // store data
  assign id_ex.pc           = id_slot.pc;

endmodule

`default_nettype wire

// File: src/branch_unit.sv
`default_nettype none

module branch_unit (
  input  id_pipe_pkg::dec_t dec,
  input  la_isa_pkg::word_t pc,
  input  la_isa_pkg::word_t rj_value,
  input  la_isa_pkg::word_t rkd_value,
  input  logic              valid,
  input  logic              stall,
  output id_pipe_pkg::br_t  br
);

  import la_isa_pkg::*;

  logic  rj_eq_rd;
  logic  rj_lt_rd;
  logic  rj_ltu_rd;
  logic  cond_ok;
  logic  is_branch;
  word_t base;

  assign rj_eq_rd  = (rj_value == rkd_value);
  assign rj_lt_rd  = ($signed(rj_value) < $signed(rkd_value));
  assign rj_ltu_rd = (rj_value < rkd_value);

  assign cond_ok = (dec.br_eq  &&  rj_eq_rd)
                || (dec.br_ne  && !rj_eq_rd)
                || (dec.br_lt  &&  rj_lt_rd)
                || (dec.br_ge  && !rj_lt_rd)
                || (dec.br_ltu &&  rj_ltu_rd)
                || (dec.br_geu && !rj_ltu_rd);

  assign is_branch = dec.is_br_cond | dec.is_b_bl | dec.is_jirl;

  assign base      = dec.is_jirl ? rj_value : pc;  // jirl is register relative
  assign br.target = base + dec.br_offs;

  // operands not ready yet, IF must hold
  assign br.stall = valid && stall && is_branch;
  assign br.taken = valid && !stall
                 && (dec.is_b_bl || dec.is_jirl || (dec.is_br_cond && cond_ok));

endmodule

`default_nettype wire

// File: src/operand_bypass.sv
`default_nettype none

module operand_bypass (
  input  id_pipe_pkg::dec_t dec,
  input  la_isa_pkg::word_t rdata1,
  input  la_isa_pkg::word_t rdata2,
  input  id_pipe_pkg::fwd_t ex_fwd,
  input  id_pipe_pkg::fwd_t mem_fwd,
  input  id_pipe_pkg::fwd_t wb_fwd,
  output la_isa_pkg::word_t rj_value,
  output la_isa_pkg::word_t rkd_value,
  output logic              stall
);

  import la_isa_pkg::*;
  import id_pipe_pkg::*;

  logic ex_hit1;
  logic ex_hit2;

  // stage writes a nonzero register that matches addr
  function automatic logic fwd_hit(input fwd_t f, input reg_addr_t addr);
    return f.we && (addr != '0) && (f.waddr == addr);
  endfunction

  // youngest result wins
  function automatic word_t fwd_pick(input reg_addr_t addr, input word_t rf_val,
                                     input fwd_t ex, input fwd_t mem, input fwd_t wb);
    if (fwd_hit(ex, addr)) begin
      return ex.wdata;
    end else if (fwd_hit(mem, addr)) begin
      return mem.wdata;
    end else if (fwd_hit(wb, addr)) begin
      return wb.wdata;
    end
    return rf_val;
  endfunction

  assign rj_value  = fwd_pick(dec.raddr1, rdata1, ex_fwd, mem_fwd, wb_fwd);
  assign rkd_value = fwd_pick(dec.raddr2, rdata2, ex_fwd, mem_fwd, wb_fwd);

  assign ex_hit1 = dec.need_r1 && fwd_hit(ex_fwd, dec.raddr1);
  assign ex_hit2 = dec.need_r2 && fwd_hit(ex_fwd, dec.raddr2);

  // load in EX: data not ready until MEM
  assign stall = ex_fwd.from_mem && (ex_hit1 || ex_hit2);

endmodule

`default_nettype wire

// File: src/regfile.sv
`default_nettype none

module regfile (
  input  logic                  clk,
  input  la_isa_pkg::reg_addr_t raddr1,
  output la_isa_pkg::word_t     rdata1,
  input  la_isa_pkg::reg_addr_t raddr2,
  output la_isa_pkg::word_t     rdata2,
  input  logic                  we,
  input  la_isa_pkg::reg_addr_t waddr,
  input  la_isa_pkg::word_t     wdata
);

  import la_isa_pkg::*;

  word_t mem [32];

  always_ff @(posedge clk) begin
    if (we && (waddr != '0)) begin
      mem[waddr] <= wdata;  // r0 never written
    end
  end

  // same-cycle write is not visible here, WB forwarding covers it
  assign rdata1 = (raddr1 == '0) ? '0 : mem[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : mem[raddr2];

endmodule

`default_nettype wire

// File: src/inst_decoder.sv
`default_nettype none

module inst_decoder (
  input  la_isa_pkg::inst_t  inst,
  output id_pipe_pkg::dec_t  dec
);

  import la_isa_pkg::*;

  logic [5:0]  op6;
  logic [3:0]  op4;
  logic [1:0]  op2;
  logic [4:0]  op5;
  reg_addr_t   rd;
  reg_addr_t   rj;
  reg_addr_t   rk;
  logic [11:0] i12;
  logic [15:0] i16;
  logic [19:0] i20;
  logic [25:0] i26;

  logic grp_reg3;
  logic grp_shifti;
  logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
  logic inst_and, inst_or, inst_nor, inst_xor;
  logic inst_sll_w, inst_srl_w, inst_sra_w;
  logic inst_slli_w, inst_srli_w, inst_srai_w;
  logic inst_slti, inst_sltui, inst_addi_w, inst_andi, inst_ori, inst_xori;
  logic inst_lu12i_w, inst_pcaddu12i, inst_ld_w, inst_st_w;
  logic inst_b, inst_bl, inst_jirl;
  logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
  logic is_alu_rr;
  logic is_alu_ri;
  logic is_br_cond;
  logic src2_is_4;
  logic need_si20;
  logic need_ui12;

  assign op6 = inst[OP6_LSB +: 6];
  assign op4 = inst[OP4_LSB +: 4];
  assign op2 = inst[OP2_LSB +: 2];
  assign op5 = inst[OP5_LSB +: 5];
  assign rd  = inst[RD_LSB +: REG_W];
  assign rj  = inst[RJ_LSB +: REG_W];
  assign rk  = inst[RK_LSB +: REG_W];
  assign i12 = inst[I12_LSB +: 12];
  assign i16 = inst[I16_LSB +: 16];
  assign i20 = inst[I20_LSB +: 20];
  assign i26 = {inst[9:0], i16};  // offs[25:16] sits in the low bits

  assign grp_reg3   = (op6 == OP_ALU) && (op4 == F4_REG3) && (op2 == F2_REG3);
  assign grp_shifti = (op6 == OP_ALU) && (op4 == F4_SHIFTI) && (op2 == F2_SHIFTI);

  assign inst_add_w  = grp_reg3 && (op5 == F5_ADD);
  assign inst_sub_w  = grp_reg3 && (op5 == F5_SUB);
  assign inst_slt    = grp_reg3 && (op5 == F5_SLT);
  assign inst_sltu   = grp_reg3 && (op5 == F5_SLTU);
  assign inst_nor    = grp_reg3 && (op5 == F5_NOR);
  assign inst_and    = grp_reg3 && (op5 == F5_AND);
  assign inst_or     = grp_reg3 && (op5 == F5_OR);
  assign inst_xor    = grp_reg3 && (op5 == F5_XOR);
  assign inst_sll_w  = grp_reg3 && (op5 == F5_SLL);
  assign inst_srl_w  = grp_reg3 && (op5 == F5_SRL);
  assign inst_sra_w  = grp_reg3 && (op5 == F5_SRA);
  assign inst_slli_w = grp_shifti && (op5 == F5_SLLI);
  assign inst_srli_w = grp_shifti && (op5 == F5_SRLI);
  assign inst_srai_w = grp_shifti && (op5 == F5_SRAI);

  assign inst_slti   = (op6 == OP_ALU) && (op4 == F4_SLTI);
  assign inst_sltui  = (op6 == OP_ALU) && (op4 == F4_SLTUI);
  assign inst_addi_w = (op6 == OP_ALU) && (op4 == F4_ADDI);
  assign inst_andi   = (op6 == OP_ALU) && (op4 == F4_ANDI);
  assign inst_ori    = (op6 == OP_ALU) && (op4 == F4_ORI);
  assign inst_xori   = (op6 == OP_ALU) && (op4 == F4_XORI);
  assign inst_ld_w   = (op6 == OP_MEM) && (op4 == F4_LD_W);
  assign inst_st_w   = (op6 == OP_MEM) && (op4 == F4_ST_W);

  assign inst_lu12i_w   = (op6 == OP_LU12I) && !inst[25];  // 7-bit opcode
  assign inst_pcaddu12i = (op6 == OP_PCADDU12I) && !inst[25];
  assign inst_jirl      = (op6 == OP_JIRL);
  assign inst_b         = (op6 == OP_B);
  assign inst_bl        = (op6 == OP_BL);
  assign inst_beq       = (op6 == OP_BEQ);
  assign inst_bne       = (op6 == OP_BNE);
  assign inst_blt       = (op6 == OP_BLT);
  assign inst_bge       = (op6 == OP_BGE);
  assign inst_bltu      = (op6 == OP_BLTU);
  assign inst_bgeu      = (op6 == OP_BGEU);

  assign is_alu_rr = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                   | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
  assign is_alu_ri = inst_slli_w | inst_srli_w | inst_srai_w | inst_slti | inst_sltui
                   | inst_addi_w | inst_andi | inst_ori | inst_xori;
  assign is_br_cond = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

  assign src2_is_4 = inst_jirl | inst_bl;  // link value pc + 4
  assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
  assign need_ui12 = inst_andi | inst_ori | inst_xori;

  always_comb begin
    dec.alu_op           = '0;
    dec.alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                         | inst_jirl | inst_bl | inst_pcaddu12i;
    dec.alu_op[ALU_SUB]  = inst_sub_w;
    dec.alu_op[ALU_SLT]  = inst_slt | inst_slti;
    dec.alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
    dec.alu_op[ALU_AND]  = inst_and | inst_andi;
    dec.alu_op[ALU_NOR]  = inst_nor;
    dec.alu_op[ALU_OR]   = inst_or | inst_ori;
    dec.alu_op[ALU_XOR]  = inst_xor | inst_xori;
    dec.alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
    dec.alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
    dec.alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
    dec.alu_op[ALU_LUI]  = inst_lu12i_w;

    dec.src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu12i;
    dec.src2_is_imm = is_alu_ri | inst_ld_w | inst_st_w | need_si20 | src2_is_4;
    dec.need_r1     = is_alu_rr | is_alu_ri | inst_ld_w | inst_st_w | inst_jirl | is_br_cond;
    dec.need_r2     = is_alu_rr | inst_st_w | is_br_cond;

    dec.rf_we    = is_alu_rr | is_alu_ri | inst_ld_w | inst_jirl | inst_bl | need_si20;
    dec.rf_waddr = inst_bl ? REG_LINK : rd;
    dec.raddr1   = rj;
    dec.raddr2   = (inst_st_w | is_br_cond) ? rd : rk;  // rd as second source

    if (src2_is_4) begin
      dec.imm = 32'h4;
    end else if (need_si20) begin
      dec.imm = {i20, 12'b0};
    end else if (need_ui12) begin
      dec.imm = {20'b0, i12};
    end else begin
      dec.imm = {{20{i12[11]}}, i12};  // si12, shift amount in low bits
    end

    dec.is_br_cond = is_br_cond;
    dec.is_b_bl    = inst_b | inst_bl;
    dec.is_jirl    = inst_jirl;
    dec.br_eq      = inst_beq;
    dec.br_ne      = inst_bne;
    dec.br_lt      = inst_blt;
    dec.br_ge      = inst_bge;
    dec.br_ltu     = inst_bltu;
    dec.br_geu     = inst_bgeu;
    dec.br_offs    = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0}
                                        : {{14{i16[15]}}, i16, 2'b0};

    dec.res_from_mem = inst_ld_w;
    dec.mem_we       = inst_st_w;
  end

endmodule

`default_nettype wire

// File: src/id_pipe_pkg.sv
`default_nettype none

package id_pipe_pkg;

  import la_isa_pkg::*;

  // IF -> ID, 64 bits
  typedef struct packed {
    inst_t inst;
    word_t pc;
  } if_id_t;

  // result fed back from EX / MEM / WB, 39 bits
  typedef struct packed {
    logic      from_mem;  // load still in flight, EX only
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } fwd_t;

  // ID -> IF, 34 bits
  typedef struct packed {
    logic  stall;
    logic  taken;
    word_t target;
  } br_t;

  // ID -> EX, 148 bits
  typedef struct packed {
    alu_op_t   alu_op;
    logic      res_from_mem;
    logic      mem_we;
    word_t     alu_src1;
    word_t     alu_src2;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rkd_value;  // store data
    word_t     pc;
  } id_ex_t;

  // decoder output, stays inside ID
  typedef struct packed {
    alu_op_t   alu_op;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      need_r1;
    logic      need_r2;
    logic      rf_we;
    reg_addr_t rf_waddr;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     imm;
    logic      is_br_cond;
    logic      is_b_bl;
    logic      is_jirl;
    logic      br_eq;
    logic      br_ne;
    logic      br_lt;
    logic      br_ge;
    logic      br_ltu;
    logic      br_geu;
    word_t     br_offs;
    logic      res_from_mem;
    logic      mem_we;
  } dec_t;

endpackage

`default_nettype wire

// File: src/la_isa_pkg.sv
`default_nettype none

package la_isa_pkg;

  localparam int XLEN     = 32;
  localparam int REG_W    = 5;
  localparam int ALU_OP_W = 12;

  typedef logic [XLEN-1:0]     word_t;
  typedef logic [31:0]         inst_t;
  typedef logic [REG_W-1:0]    reg_addr_t;
  typedef logic [ALU_OP_W-1:0] alu_op_t;  // one-hot

  // instruction field positions (lsb)
  localparam int RD_LSB  = 0;
  localparam int RJ_LSB  = 5;
  localparam int RK_LSB  = 10;
  localparam int I12_LSB = 10;
  localparam int I16_LSB = 10;
  localparam int I20_LSB = 5;
  localparam int OP5_LSB = 15;
  localparam int OP2_LSB = 20;
  localparam int OP4_LSB = 22;
  localparam int OP6_LSB = 26;

  // one-hot bit positions in alu_op_t
  localparam int ALU_ADD  = 0;
  localparam int ALU_SUB  = 1;
  localparam int ALU_SLT  = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_AND  = 4;
  localparam int ALU_NOR  = 5;
  localparam int ALU_OR   = 6;
  localparam int ALU_XOR  = 7;
  localparam int ALU_SLL  = 8;
  localparam int ALU_SRL  = 9;
  localparam int ALU_SRA  = 10;
  localparam int ALU_LUI  = 11;

  // major opcode, inst[31:26]
  localparam logic [5:0] OP_ALU       = 6'h00;
  localparam logic [5:0] OP_LU12I     = 6'h05;
  localparam logic [5:0] OP_PCADDU12I = 6'h07;
  localparam logic [5:0] OP_MEM       = 6'h0a;
  localparam logic [5:0] OP_JIRL      = 6'h13;
  localparam logic [5:0] OP_B         = 6'h14;
  localparam logic [5:0] OP_BL        = 6'h15;
  localparam logic [5:0] OP_BEQ       = 6'h16;
  localparam logic [5:0] OP_BNE       = 6'h17;
  localparam logic [5:0] OP_BLT       = 6'h18;
  localparam logic [5:0] OP_BGE       = 6'h19;
  localparam logic [5:0] OP_BLTU      = 6'h1a;
  localparam logic [5:0] OP_BGEU      = 6'h1b;

  // minor fields inst[25:22], inst[21:20], inst[19:15]
  localparam logic [3:0] F4_REG3   = 4'h0;
  localparam logic [3:0] F4_SHIFTI = 4'h1;
  localparam logic [3:0] F4_LD_W   = 4'h2;
  localparam logic [3:0] F4_ST_W   = 4'h6;
  localparam logic [3:0] F4_SLTI   = 4'h8;
  localparam logic [3:0] F4_SLTUI  = 4'h9;
  localparam logic [3:0] F4_ADDI   = 4'ha;
  localparam logic [3:0] F4_ANDI   = 4'hd;
  localparam logic [3:0] F4_ORI    = 4'he;
  localparam logic [3:0] F4_XORI   = 4'hf;
  localparam logic [1:0] F2_REG3   = 2'h1;
  localparam logic [1:0] F2_SHIFTI = 2'h0;
  localparam logic [4:0] F5_ADD    = 5'h00;
  localparam logic [4:0] F5_SUB    = 5'h02;
  localparam logic [4:0] F5_SLT    = 5'h04;
  localparam logic [4:0] F5_SLTU   = 5'h05;
  localparam logic [4:0] F5_NOR    = 5'h08;
  localparam logic [4:0] F5_AND    = 5'h09;
  localparam logic [4:0] F5_OR     = 5'h0a;
  localparam logic [4:0] F5_XOR    = 5'h0b;
  localparam logic [4:0] F5_SLL    = 5'h0e;
  localparam logic [4:0] F5_SRL    = 5'h0f;
  localparam logic [4:0] F5_SRA    = 5'h10;
  localparam logic [4:0] F5_SLLI   = 5'h01;
  localparam logic [4:0] F5_SRLI   = 5'h09;
  localparam logic [4:0] F5_SRAI   = 5'h11;

  localparam reg_addr_t REG_LINK = 5'd1;  // bl writes r1

endpackage

`default_nettype wire
